// ==== Bender.yml ====
package:
  name: huff_pair_decoder

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/huff_stream_pkg.sv
      - hdl/huff_sample_pkg.sv
      - hdl/huff_code_shifter.sv
      - hdl/huff_table20_codebook.sv
      - hdl/huff_pair_sequencer.sv
      - hdl/huff_pair_decoder.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/tb_huff_pair_decoder.sv

// ==== bench/tb_huff_pair_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_macros.svh"

module tb_huff_pair_decoder import huff_sample_pkg::*; ();

	localparam int NUM_ROWS = 11;
	localparam int DRAIN_LIMIT = 200;   // Cycles allowed for outputs to appear
	localparam int MAX_GAP = 3;
	localparam logic [`HT_MAX_CODE_BITS-1:0] BAD_PREFIX = 10'b0000111101;

	logic clk;
	logic rst;
	logic bit_valid;
	logic bit_data;
	logic pair_valid;
	logic code_error;
	sample_t x_val;
	sample_t y_val;

	// Stimulus rows, code right-aligned and sent from bit len-1 down
	logic [`HT_MAX_CODE_BITS-1:0] row_code [NUM_ROWS];
	int row_len [NUM_ROWS];
	int row_x [NUM_ROWS];
	int row_y [NUM_ROWS];
	logic [`HT_LINBITS-1:0] row_xlin [NUM_ROWS];
	logic [`HT_LINBITS-1:0] row_ylin [NUM_ROWS];
	logic row_xsign [NUM_ROWS];
	logic row_ysign [NUM_ROWS];

	int exp_x [$];
	int exp_y [$];
	int errors_seen;

	huff_pair_decoder dut0 (
		.clk(clk),
		.rst(rst),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val),
		.code_error(code_error)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic set_row(input int r, input logic [`HT_MAX_CODE_BITS-1:0] code, input int len,
			input int x, input int y, input logic [`HT_LINBITS-1:0] xl,
			input logic [`HT_LINBITS-1:0] yl, input logic xs, input logic ys);
		row_code[r] = code;
		row_len[r] = len;
		row_x[r] = x;
		row_y[r] = y;
		row_xlin[r] = xl;
		row_ylin[r] = yl;
		row_xsign[r] = xs;
		row_ysign[r] = ys;
	endtask

	task automatic load_table();
		set_row(0, 10'b1, 1, 0, 0, 6'h00, 6'h00, 1'b0, 1'b0);
		set_row(1, 10'b011, 3, 1, 0, 6'h00, 6'h00, 1'b1, 1'b0);
		set_row(2, 10'b0101, 4, 0, 1, 6'h00, 6'h00, 1'b0, 1'b0);
		set_row(3, 10'b001111, 6, 2, 0, 6'h00, 6'h00, 1'b0, 1'b0);
		set_row(4, 10'b00001001, 8, 1, 15, 6'h00, 6'h2a, 1'b0, 1'b1);
		set_row(5, 10'b00000011, 8, 15, 15, 6'h3f, 6'h05, 1'b0, 1'b1);
		set_row(6, 10'b0100, 4, 1, 1, 6'h00, 6'h00, 1'b0, 1'b1);
		set_row(7, 10'b00001010, 8, 15, 1, 6'h00, 6'h00, 1'b1, 1'b1);
		set_row(8, 10'b000010001, 9, 0, 15, 6'h00, 6'h11, 1'b0, 1'b0);
		set_row(9, 10'b0001101110, 10, 0, 6, 6'h00, 6'h00, 1'b0, 1'b1);
		set_row(10, 10'b0000001001, 10, 15, 7, 6'h20, 6'h00, 1'b0, 1'b0);
	endtask

	// Magnitude, extended by linbits on escape, negated by the sign bit
	function automatic int expected_value(input int mag, input logic [`HT_LINBITS-1:0] lin,
			input logic sign);
		int v;
		v = mag;
		if (mag == `HT_ESC_MAG)
			v = v + int'(lin);
		if (sign && (mag != 0))
			v = -v;
		return v;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_value(input string what, input int got, input int exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic drive_bit(input logic b, input int max_gap);
		int gap;
		gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
		repeat (gap) begin
			@(negedge clk);
			bit_valid = 1'b0;
			bit_data = 1'($urandom_range(1, 0));   // Noise while idle
		end
		@(negedge clk);
		bit_valid = 1'b1;
		bit_data = b;
	endtask

	task automatic go_idle();
		@(negedge clk);
		bit_valid = 1'b0;
		bit_data = 1'b0;
	endtask

	// Code, then x linbits and sign, then y linbits and sign
	task automatic send_row(input int r, input int max_gap);
		int i;
		exp_x.push_back(expected_value(row_x[r], row_xlin[r], row_xsign[r]));
		exp_y.push_back(expected_value(row_y[r], row_ylin[r], row_ysign[r]));
		for (i = row_len[r] - 1; i >= 0; i--)
			drive_bit(row_code[r][i], max_gap);
		if (row_x[r] == `HT_ESC_MAG)
			for (i = `HT_LINBITS - 1; i >= 0; i--)
				drive_bit(row_xlin[r][i], max_gap);
		if (row_x[r] != 0)
			drive_bit(row_xsign[r], max_gap);
		if (row_y[r] == `HT_ESC_MAG)
			for (i = `HT_LINBITS - 1; i >= 0; i--)
				drive_bit(row_ylin[r][i], max_gap);
		if (row_y[r] != 0)
			drive_bit(row_ysign[r], max_gap);
	endtask

	task automatic wait_for_pairs(input string what);
		int cycles;
		cycles = 0;
		while ((exp_x.size() != 0) && (cycles < DRAIN_LIMIT)) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_x.size() != 0)
			fail_run($sformatf("timeout: %0d pairs of the %s never came out", exp_x.size(), what));
	endtask

	task automatic wait_for_error(input int target);
		int cycles;
		cycles = 0;
		while ((errors_seen < target) && (cycles < DRAIN_LIMIT)) begin
			@(negedge clk);
			cycles++;
		end
		if (errors_seen < target)
			fail_run("timeout: code_error never pulsed for the unmatched prefix");
	endtask

	// Outputs are registered, so they are steady at the falling edge
	always @(negedge clk) begin
		if (!rst && pair_valid) begin
			if (exp_x.size() == 0) begin
				fail_run($sformatf("pair_valid pulsed at %0t with no pair pending", $time));
			end else begin
				check_value("x_val", x_val, exp_x.pop_front());
				check_value("y_val", y_val, exp_y.pop_front());
			end
		end
		if (!rst && code_error)
			errors_seen++;
	end

	initial begin
		int r;
		int i;
		rst = 1'b1;
		bit_valid = 1'b0;
		bit_data = 1'b0;
		errors_seen = 0;
		void'($urandom(66));
		load_table();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (r = 0; r < NUM_ROWS; r++) begin   // One pair at a time
			send_row(r, 0);
			go_idle();
			wait_for_pairs("isolated rows");
		end

		for (r = 0; r < NUM_ROWS; r++)
			send_row(r, 0);   // Next code starts in the match cycle
		go_idle();
		wait_for_pairs("back-to-back stream");

		for (r = 0; r < NUM_ROWS; r++)
			send_row(r, MAX_GAP);
		go_idle();
		wait_for_pairs("stream with idle gaps");

		// Ten bits with no match, then a code 1 right behind them
		for (i = `HT_MAX_CODE_BITS - 1; i >= 0; i--)
			drive_bit(BAD_PREFIX[i], 0);
		send_row(0, 0);
		go_idle();
		wait_for_error(1);
		wait_for_pairs("pair after the code error");

		check_value("code_error pulses", errors_seen, 1);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/huff_code_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_macros.svh"

module huff_code_shifter import huff_stream_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic bit_data,
	input wire logic shift_en,
	input wire logic restart,
	output code_bits_t code_bits,
	output code_len_t code_len
);

	localparam int MSB = `HT_MAX_CODE_BITS - 1;

	always_ff @(posedge clk) begin
		if (rst) begin
			code_bits <= '0;
			code_len <= '0;
		end else if (restart) begin
			// A bit taken while restarting opens the next code
			code_bits <= shift_en ? {bit_data, {MSB{1'b0}}} : '0;
			code_len <= shift_en ? code_len_t'(1) : '0;
		end else if (shift_en) begin
			code_bits[MSB - code_len] <= bit_data;   // Next free slot from the top
			code_len <= code_len + 1'b1;
		end
	end

	// Sequencer must restart the shifter by the time the longest code is in
	len_in_range: assert property (@(posedge clk) disable iff (rst)
		code_len <= code_len_t'(`HT_MAX_CODE_BITS));

endmodule

`default_nettype wire

// ==== hdl/huff_macros.svh ====
`ifndef HUFF_MACROS_SVH
`define HUFF_MACROS_SVH

// Longest table-20 code the decoder matches
`define HT_MAX_CODE_BITS 10

`define HT_LINBITS 6         // Table 20 escape extension
`define HT_ESC_MAG 15        // Magnitude that pulls in linbits

`define HT_MAG_BITS 4
`define HT_SAMPLE_BITS 16

`endif

// ==== hdl/huff_pair_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module huff_pair_decoder import huff_stream_pkg::*, huff_sample_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic bit_valid,
	input wire logic bit_data,
	output logic pair_valid,
	output sample_t x_val,
	output sample_t y_val,
	output logic code_error
);

	code_bits_t code_bits;
	code_len_t code_len;
	logic hit;
	logic shift_en;
	logic restart;
	mag_t x_mag, y_mag;

	huff_code_shifter shifter0 (
		.clk(clk),
		.rst(rst),
		.bit_data(bit_data),
		.shift_en(shift_en),
		.restart(restart),
		.code_bits(code_bits),
		.code_len(code_len)
	);

	huff_table20_codebook codebook0 (
		.code_bits(code_bits),
		.code_len(code_len),
		.hit(hit),
		.x_mag(x_mag),
		.y_mag(y_mag)
	);

	huff_pair_sequencer sequencer0 (
		.clk(clk),
		.rst(rst),
		.bit_valid(bit_valid),
		.bit_data(bit_data),
		.hit(hit),
		.x_mag(x_mag),
		.y_mag(y_mag),
		.code_len(code_len),
		.shift_en(shift_en),
		.restart(restart),
		.pair_valid(pair_valid),
		.x_val(x_val),
		.y_val(y_val),
		.code_error(code_error)
	);

endmodule

`default_nettype wire

// ==== hdl/huff_pair_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_macros.svh"

module huff_pair_sequencer import huff_stream_pkg::*, huff_sample_pkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic bit_valid,
	input wire logic bit_data,
	input wire logic hit,
	input wire mag_t x_mag,
	input wire mag_t y_mag,
	input wire code_len_t code_len,
	output logic shift_en,
	output logic restart,
	output logic pair_valid,
	output sample_t x_val,
	output sample_t y_val,
	output logic code_error
);

	localparam int CNT_BITS = $clog2(`HT_LINBITS);
	localparam mag_t ESC = mag_t'(`HT_ESC_MAG);

	field_phase_t phase, eff_phase, phase_n;
	mag_t x_mag_r, y_mag_r, cur_x, cur_y;
	linval_t x_lin_r, y_lin_r, x_lin_n, y_lin_n;
	logic x_sign_r, y_sign_r, x_sign_n, y_sign_n;
	logic [CNT_BITS-1:0] lin_cnt, lin_cnt_n;
	logic match, lin_last, field_done, pair_done;
	sample_t x_abs, y_abs;

	// Field that follows cur for a pair with magnitudes x and y
	function automatic field_phase_t field_after(field_phase_t cur, mag_t x, mag_t y);
		field_phase_t nxt;
		nxt = CODE;
		case (cur)
			CODE: begin
				if (x == ESC)
					nxt = X_LIN;
				else if (x != '0)
					nxt = X_SIGN;
				else if (y == ESC)
					nxt = Y_LIN;
				else if (y != '0)
					nxt = Y_SIGN;
			end
			X_LIN: nxt = X_SIGN;
			X_SIGN: begin
				if (y == ESC)
					nxt = Y_LIN;
				else if (y != '0)
					nxt = Y_SIGN;
			end
			Y_LIN: nxt = Y_SIGN;
			default: nxt = CODE;
		endcase
		return nxt;
	endfunction

	assign match = (phase == CODE) && hit;
	assign code_error = (phase == CODE) && !hit
		&& (code_len == code_len_t'(`HT_MAX_CODE_BITS));
	assign restart = match || code_error;

	// Fresh magnitudes are in use from the match cycle on
	assign cur_x = match ? x_mag : x_mag_r;
	assign cur_y = match ? y_mag : y_mag_r;

	// A bit in the match cycle already belongs to the first pending field
	assign eff_phase = match ? field_after(CODE, x_mag, y_mag) : phase;
	assign shift_en = bit_valid && (eff_phase == CODE);

	assign lin_last = (lin_cnt == CNT_BITS'(`HT_LINBITS - 1));

	always_comb begin
		x_lin_n = match ? '0 : x_lin_r;
		y_lin_n = match ? '0 : y_lin_r;
		x_sign_n = match ? 1'b0 : x_sign_r;
		y_sign_n = match ? 1'b0 : y_sign_r;
		lin_cnt_n = lin_cnt;
		field_done = 1'b0;
		if (bit_valid) begin
			case (eff_phase)
				X_LIN: begin
					x_lin_n = {x_lin_n[`HT_LINBITS-2:0], bit_data};   // MSB first
					field_done = lin_last;
					lin_cnt_n = lin_last ? '0 : lin_cnt + 1'b1;
				end
				Y_LIN: begin
					y_lin_n = {y_lin_n[`HT_LINBITS-2:0], bit_data};
					field_done = lin_last;
					lin_cnt_n = lin_last ? '0 : lin_cnt + 1'b1;
				end
				X_SIGN: begin
					x_sign_n = bit_data;
					field_done = 1'b1;
				end
				Y_SIGN: begin
					y_sign_n = bit_data;
					field_done = 1'b1;
				end
				default: field_done = 1'b0;   // Code bit, shifter takes it
			endcase
		end
		phase_n = field_done ? field_after(eff_phase, cur_x, cur_y) : eff_phase;
		pair_done = (phase_n == CODE) && ((eff_phase != CODE) || match);
	end

	// Linbits stay zero unless the magnitude is the escape
	assign x_abs = sample_t'(cur_x) + sample_t'(x_lin_n);
	assign y_abs = sample_t'(cur_y) + sample_t'(y_lin_n);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= CODE;
			lin_cnt <= '0;
			pair_valid <= 1'b0;
		end else begin
			phase <= phase_n;
			lin_cnt <= lin_cnt_n;
			pair_valid <= pair_done;
		end
	end

	always_ff @(posedge clk) begin
		if (match) begin
			x_mag_r <= x_mag;
			y_mag_r <= y_mag;
		end
		x_lin_r <= x_lin_n;
		y_lin_r <= y_lin_n;
		x_sign_r <= x_sign_n;
		y_sign_r <= y_sign_n;
		if (pair_done) begin
			x_val <= x_sign_n ? -x_abs : x_abs;
			y_val <= y_sign_n ? -y_abs : y_abs;
		end
	end

	// An error restart can never close a pair
	valid_not_error: assert property (@(posedge clk) disable iff (rst)
		!(pair_valid && code_error));

	// Every code bit taken outside a restart lands in the shifter
	code_bit_counted: assert property (@(posedge clk) disable iff (rst)
		shift_en && !restart |=> code_len == $past(code_len) + 1'b1);

endmodule

`default_nettype wire

// ==== hdl/huff_sample_pkg.sv ====
`default_nettype none

`include "huff_macros.svh"

package huff_sample_pkg;

	typedef logic [`HT_MAG_BITS-1:0] mag_t;                // Table magnitude
	typedef logic [`HT_LINBITS-1:0] linval_t;              // Escape extension
	typedef logic signed [`HT_SAMPLE_BITS-1:0] sample_t;   // Signed decoded value

	// Fields of one pair in stream order
	typedef enum logic [2:0] {
		CODE,
		X_LIN,
		X_SIGN,
		Y_LIN,
		Y_SIGN
	} field_phase_t;

endpackage

`default_nettype wire

// ==== hdl/huff_stream_pkg.sv ====
`default_nettype none

`include "huff_macros.svh"

package huff_stream_pkg;

	// Code bits as they arrive, first bit in the MSB
	typedef logic [`HT_MAX_CODE_BITS-1:0] code_bits_t;

	// Count of collected code bits, 0 up to the longest code
	typedef logic [$clog2(`HT_MAX_CODE_BITS+1)-1:0] code_len_t;

endpackage

`default_nettype wire

// ==== hdl/huff_table20_codebook.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "huff_macros.svh"

module huff_table20_codebook
	import huff_stream_pkg::*;
	import huff_sample_pkg::mag_t;
(
	input wire code_bits_t code_bits,
	input wire code_len_t code_len,
	output logic hit,
	output mag_t x_mag,
	output mag_t y_mag
);

	localparam int MSB = `HT_MAX_CODE_BITS - 1;

	logic [2*`HT_MAG_BITS:0] entry;   // {hit, x, y}

	function automatic logic [2*`HT_MAG_BITS:0] pair(input mag_t x, input mag_t y);
		return {1'b1, x, y};
	endfunction

	assign {hit, x_mag, y_mag} = entry;

	always_comb begin
		entry = '0;
		case (code_len)
			4'd1: case (code_bits[MSB -: 1])
				1'b1: entry = pair(4'd0, 4'd0);
			endcase
			4'd3: case (code_bits[MSB -: 3])
				3'b011: entry = pair(4'd1, 4'd0);
			endcase
			4'd4: case (code_bits[MSB -: 4])
				4'b0101: entry = pair(4'd0, 4'd1);
				4'b0100: entry = pair(4'd1, 4'd1);
			endcase
			4'd6: case (code_bits[MSB -: 6])
				6'b001110: entry = pair(4'd0, 4'd2);
				6'b001100: entry = pair(4'd1, 4'd2);
				6'b001111: entry = pair(4'd2, 4'd0);
				6'b001101: entry = pair(4'd2, 4'd1);
			endcase
			4'd7: case (code_bits[MSB -: 7])
				7'b0010100: entry = pair(4'd1, 4'd3);
				7'b0010111: entry = pair(4'd2, 4'd2);
				7'b0010101: entry = pair(4'd3, 4'd1);
			endcase
			4'd8: case (code_bits[MSB -: 8])
				8'b00101100: entry = pair(4'd0, 4'd3);
				8'b00100011: entry = pair(4'd1, 4'd4);
				8'b00001001: entry = pair(4'd1, 4'd15);
				8'b00100110: entry = pair(4'd2, 4'd3);
				8'b00101101: entry = pair(4'd3, 4'd0);
				8'b00100111: entry = pair(4'd3, 4'd2);
				8'b00100100: entry = pair(4'd4, 4'd1);
				8'b00011110: entry = pair(4'd5, 4'd1);
				8'b00001010: entry = pair(4'd15, 4'd1);
				8'b00000111: entry = pair(4'd15, 4'd2);
				8'b00000011: entry = pair(4'd15, 4'd15);
			endcase
			4'd9: case (code_bits[MSB -: 9])
				9'b001001010: entry = pair(4'd0, 4'd4);
				9'b000111111: entry = pair(4'd0, 4'd5);
				9'b000010001: entry = pair(4'd0, 4'd15);
				9'b000111110: entry = pair(4'd1, 4'd5);
				9'b000110101: entry = pair(4'd1, 4'd6);
				9'b000101111: entry = pair(4'd1, 4'd7);
				9'b001000011: entry = pair(4'd2, 4'd4);
				9'b000111010: entry = pair(4'd2, 4'd5);
				9'b000010000: entry = pair(4'd2, 4'd15);
				9'b001000101: entry = pair(4'd3, 4'd3);
				9'b001000000: entry = pair(4'd3, 4'd4);
				9'b001001011: entry = pair(4'd4, 4'd0);
				9'b001000100: entry = pair(4'd4, 4'd2);
				9'b001000001: entry = pair(4'd4, 4'd3);
				9'b000001001: entry = pair(4'd4, 4'd15);
				9'b001000010: entry = pair(4'd5, 4'd0);
				9'b000111011: entry = pair(4'd5, 4'd2);
				9'b000111000: entry = pair(4'd5, 4'd3);
				9'b000110110: entry = pair(4'd6, 4'd1);
				9'b000110100: entry = pair(4'd6, 4'd2);
				9'b000110000: entry = pair(4'd7, 4'd1);
				9'b000001100: entry = pair(4'd15, 4'd0);
				9'b000001011: entry = pair(4'd15, 4'd3);
				9'b000001010: entry = pair(4'd15, 4'd4);
			endcase
			4'd10: case (code_bits[MSB -: 10])
				10'b0001101110: entry = pair(4'd0, 4'd6);
				10'b0001011101: entry = pair(4'd0, 4'd7);
				10'b0001010011: entry = pair(4'd1, 4'd8);
				10'b0001001011: entry = pair(4'd1, 4'd9);
				10'b0001000100: entry = pair(4'd1, 4'd10);
				10'b0001100111: entry = pair(4'd2, 4'd6);
				10'b0001011010: entry = pair(4'd2, 4'd7);
				10'b0001001000: entry = pair(4'd2, 4'd9);
				10'b0001110010: entry = pair(4'd3, 4'd5);
				10'b0001100011: entry = pair(4'd3, 4'd6);
				10'b0001010111: entry = pair(4'd3, 4'd7);
				10'b0000011010: entry = pair(4'd3, 4'd15);
				10'b0001110011: entry = pair(4'd4, 4'd4);
				10'b0001100101: entry = pair(4'd4, 4'd5);
				10'b0001100110: entry = pair(4'd5, 4'd4);
				10'b0000010000: entry = pair(4'd5, 4'd15);
				10'b0001101111: entry = pair(4'd6, 4'd0);
				10'b0001100100: entry = pair(4'd6, 4'd3);
				10'b0000001010: entry = pair(4'd6, 4'd15);
				10'b0001100010: entry = pair(4'd7, 4'd0);
				10'b0001011011: entry = pair(4'd7, 4'd2);
				10'b0001011000: entry = pair(4'd7, 4'd3);
				10'b0000001000: entry = pair(4'd7, 4'd15);
				10'b0001010101: entry = pair(4'd8, 4'd0);
				10'b0001010100: entry = pair(4'd8, 4'd1);
				10'b0001010001: entry = pair(4'd8, 4'd2);
				10'b0000000111: entry = pair(4'd8, 4'd15);
				10'b0001001100: entry = pair(4'd9, 4'd1);
				10'b0001001001: entry = pair(4'd9, 4'd2);
				10'b0001000011: entry = pair(4'd10, 4'd2);
				10'b0000000100: entry = pair(4'd10, 4'd15);
				10'b0000010001: entry = pair(4'd15, 4'd5);
				10'b0000001011: entry = pair(4'd15, 4'd6);
				10'b0000001001: entry = pair(4'd15, 4'd7);
			endcase
			default: entry = '0;   // Lengths with no code
		endcase
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/huff_stream_pkg.sv
hdl/huff_sample_pkg.sv
hdl/huff_code_shifter.sv
hdl/huff_table20_codebook.sv
hdl/huff_pair_sequencer.sv
hdl/huff_pair_decoder.sv
bench/tb_huff_pair_decoder.sv
